//--- files.f
+incdir+hdl
hdl/vga_bus_pkg.sv
hdl/vga_regs_pkg.sv
hdl/lut_ram.sv
hdl/vga_config_regs.sv
hdl/vga_palette_top.sv
tests/vga_palette_assertions.sv
tests/tb_vga_palette.sv

//--- hdl/lut_ram.sv
// colour look-up table with one host read/write port and one video read port
// both reads registered, instantiated for the attribute palette and the dac
`timescale 1ns/1ps

module lut_ram
  import vga_bus_pkg::*;
#(
  parameter type entry_t = attr_entry_t,
  parameter int  DEPTH   = 16
)
(
  input  logic                     wb_clk_i,
  input  logic                     host_we_i,
  input  logic [$clog2(DEPTH)-1:0] host_addr_i,
  input  entry_t                   host_wdata_i,
  output entry_t                   host_rdata_o,
  input  logic [$clog2(DEPTH)-1:0] vid_addr_i,
  output entry_t                   vid_rdata_o
);

  entry_t mem [DEPTH];

  // tables come up black
  initial
  begin
    for (int i = 0; i < DEPTH; i++)
      mem[i] = '0;
  end

  always @(posedge wb_clk_i)
  begin
    if (host_we_i)
      mem[host_addr_i] <= host_wdata_i;
    host_rdata_o <= mem[host_addr_i];  // old entry on same-address write
  end

  // video side streams every cycle
  always @(posedge wb_clk_i)
  begin
    vid_rdata_o <= mem[vid_addr_i];
  end

endmodule

//--- hdl/vga_bus_pkg.sv
// host bus request and colour table entry types
// shared by the register block, the colour tables and the top level
`include "vga_params.svh"

package vga_bus_pkg;

  // one wishbone slave request, as seen by the register block
  typedef struct packed {
    logic [`VGA_DAT_W-1:0] dat;
    logic [`VGA_ADR_W-1:0] adr;
    logic                  we;
    logic [1:0]            sel;  // sel[0] low byte, sel[1] high byte
    logic                  stb;
  } wb_req_t;

  // dac entry, 6 bits per gun
  typedef struct packed {
    logic [`VGA_COMP_W-1:0] red;
    logic [`VGA_COMP_W-1:0] green;
    logic [`VGA_COMP_W-1:0] blue;
  } rgb18_t;

  // attribute palette entry, indexes the dac
  typedef logic [`VGA_DAC_AW-1:0] attr_entry_t;

endpackage

//--- hdl/vga_config_regs.sv
// wishbone register block: sequencer, graphics and crtc index/data pairs,
// attribute flip-flop and dac index counters driving the two colour tables
`timescale 1ns/1ps
`include "vga_params.svh"

module vga_config_regs
  import vga_bus_pkg::*;
  import vga_regs_pkg::*;
(
  input  logic                    wb_clk_i,
  input  logic                    arst_n_i,
  input  wb_req_t                 wb_req_i,
  output logic [`VGA_DAT_W-1:0]   wb_dat_o,
  output logic                    wb_ack_o,
  output graph_cfg_t              graph_cfg_o,
  output crtc_cfg_t               crtc_cfg_o,
  output logic [3:0]              map_mask_o,
  output logic                    attr_we_o,
  output logic [`VGA_ATTR_AW-1:0] attr_addr_o,
  output attr_entry_t             attr_wdata_o,
  input  attr_entry_t             attr_rdata_i,
  output logic                    dac_we_o,
  output logic [`VGA_DAC_AW-1:0]  dac_addr_o,
  output rgb18_t                  dac_wdata_o,
  input  rgb18_t                  dac_rdata_i,
  input  logic                    v_retrace_i,
  input  logic                    vh_retrace_i
);

  logic [7:0] graph_file [`VGA_GRAPH_REGS];
  logic [7:0] crtc_file [`VGA_CRTC_REGS];

  logic [`VGA_SEQ_IDX_W-1:0]   seq_idx, seq_idx_wr;
  logic [`VGA_GRAPH_IDX_W-1:0] graph_idx, graph_idx_wr;
  logic [`VGA_CRTC_IDX_W-1:0]  crtc_idx, crtc_idx_wr;
  logic [7:0]                  graph_rd, crtc_rd;

  logic                    flip_flop;
  logic                    pal_hi;  // bit 4 of the palette address
  logic [`VGA_ATTR_AW-1:0] pal_addr;

  logic [`VGA_DAC_AW-1:0]  dac_wr_idx, dac_wr_idx_eff, dac_rd_idx;
  logic [1:0]              dac_wr_cyc, dac_wr_cyc_eff, dac_rd_cyc;
  logic [`VGA_COMP_W-1:0]  dac_red, dac_green, dac_comp;
  logic [1:0]              dac_state;
  logic                    ack_delay;

  logic wr, rd;
  logic wr_seq, wr_graph, wr_crtc;
  logic wr_attr, rd_attr, rd_status;
  logic pel_adr_rd, pel_adr_wr, wr_dac, rd_dac;
  logic tbl_rd, dac_rd_step;

  // bus decode
  assign wr       = wb_req_i.stb & wb_req_i.we;
  assign rd       = wb_req_i.stb & ~wb_req_i.we;
  assign wr_seq   = wr && (wb_req_i.adr == `VGA_ADR_SEQ);
  assign wr_graph = wr && (wb_req_i.adr == `VGA_ADR_GRAPH);
  assign wr_crtc  = wr && (wb_req_i.adr == `VGA_ADR_CRTC);

  assign wr_attr   = wr && (wb_req_i.adr == `VGA_ADR_ATTR) && wb_req_i.sel[0];
  assign rd_attr   = rd && (wb_req_i.adr == `VGA_ADR_ATTR) && wb_req_i.sel[1];
  assign rd_status = rd && (wb_req_i.adr == `VGA_ADR_STATUS) && wb_req_i.sel[0];

  assign pel_adr_rd = wr && (wb_req_i.adr == `VGA_ADR_PEL_RD) && wb_req_i.sel[1];
  assign pel_adr_wr = wr && (wb_req_i.adr == `VGA_ADR_DAC) && wb_req_i.sel[0];
  assign wr_dac     = wr && (wb_req_i.adr == `VGA_ADR_DAC) && wb_req_i.sel[1];
  assign rd_dac     = rd && (wb_req_i.adr == `VGA_ADR_DAC) && wb_req_i.sel[1];

  // table reads wait one cycle for the registered read data
  assign tbl_rd      = rd_attr | rd_dac;
  assign wb_ack_o    = tbl_rd ? ack_delay : wb_req_i.stb;
  assign dac_rd_step = rd_dac & ack_delay;

  always_ff @(posedge wb_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      ack_delay <= 1'b0;
    else
      ack_delay <= tbl_rd & ~ack_delay;  // single pulse per read
  end

  // a high-byte write lands at the index written in the same cycle
  assign seq_idx_wr   = (wr_seq && wb_req_i.sel[0]) ? wb_req_i.dat[3:0] : seq_idx;
  assign graph_idx_wr = (wr_graph && wb_req_i.sel[0]) ? wb_req_i.dat[3:0] : graph_idx;
  assign crtc_idx_wr  = (wr_crtc && wb_req_i.sel[0]) ? wb_req_i.dat[4:0] : crtc_idx;

  always_ff @(posedge wb_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      seq_idx    <= '0;
      graph_idx  <= '0;
      crtc_idx   <= '0;
      map_mask_o <= 4'h0;
    end
    else
    begin
      seq_idx   <= seq_idx_wr;
      graph_idx <= graph_idx_wr;
      crtc_idx  <= crtc_idx_wr;
      if (wr_seq && wb_req_i.sel[1] && seq_idx_wr == `VGA_SEQ_MAP_MASK)
        map_mask_o <= wb_req_i.dat[11:8];
    end
  end

  always_ff @(posedge wb_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      for (int i = 0; i < `VGA_GRAPH_REGS; i++)
        graph_file[i] <= 8'h00;
      for (int j = 0; j < `VGA_CRTC_REGS; j++)
        crtc_file[j] <= 8'h00;
    end
    else
    begin
      // indices past the file end are ignored
      if (wr_graph && wb_req_i.sel[1] && graph_idx_wr < `VGA_GRAPH_REGS)
        graph_file[graph_idx_wr] <= wb_req_i.dat[15:8];
      if (wr_crtc && wb_req_i.sel[1] && crtc_idx_wr < `VGA_CRTC_REGS)
        crtc_file[crtc_idx_wr] <= wb_req_i.dat[15:8];
    end
  end

  // attribute controller, first write loads the address, second the data
  always_ff @(posedge wb_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      flip_flop <= 1'b0;
      pal_hi    <= 1'b0;
      pal_addr  <= '0;
    end
    else
    begin
      if (rd_status)
        flip_flop <= 1'b0;
      else if (wr_attr)
        flip_flop <= ~flip_flop;
      if (wr_attr && !flip_flop)
        {pal_hi, pal_addr} <= wb_req_i.dat[4:0];
    end
  end

  assign attr_we_o    = wr_attr & flip_flop & ~pal_hi;
  assign attr_addr_o  = pal_addr;
  assign attr_wdata_o = wb_req_i.dat[7:0];

  // dac write side, index load in the same word restarts the cycle
  assign dac_wr_idx_eff = pel_adr_wr ? wb_req_i.dat[7:0] : dac_wr_idx;
  assign dac_wr_cyc_eff = pel_adr_wr ? 2'd0 : dac_wr_cyc;

  assign dac_we_o    = wr_dac && (dac_wr_cyc_eff == 2'd2);  // blue commits
  assign dac_addr_o  = dac_we_o ? dac_wr_idx_eff : dac_rd_idx;
  assign dac_wdata_o = '{red: dac_red, green: dac_green, blue: wb_req_i.dat[13:8]};

  always_ff @(posedge wb_clk_i)
  begin
    if (wr_dac && dac_wr_cyc_eff == 2'd0)
      dac_red <= wb_req_i.dat[13:8];
    if (wr_dac && dac_wr_cyc_eff == 2'd1)
      dac_green <= wb_req_i.dat[13:8];
  end

  always_ff @(posedge wb_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      dac_wr_idx <= '0;
      dac_wr_cyc <= 2'd0;
      dac_rd_idx <= '0;
      dac_rd_cyc <= 2'd0;
      dac_state  <= 2'b01;
    end
    else
    begin
      if (wr_dac)
      begin
        dac_wr_cyc <= (dac_wr_cyc_eff == 2'd2) ? 2'd0 : dac_wr_cyc_eff + 2'd1;
        dac_wr_idx <= dac_we_o ? dac_wr_idx_eff + 1'b1 : dac_wr_idx_eff;
      end
      else if (pel_adr_wr)
      begin
        dac_wr_idx <= wb_req_i.dat[7:0];
        dac_wr_cyc <= 2'd0;
      end

      if (pel_adr_rd)
      begin
        dac_rd_idx <= wb_req_i.dat[15:8];
        dac_rd_cyc <= 2'd0;
      end
      else if (dac_rd_step)
      begin
        dac_rd_cyc <= (dac_rd_cyc == 2'd2) ? 2'd0 : dac_rd_cyc + 2'd1;
        if (dac_rd_cyc == 2'd2)
          dac_rd_idx <= dac_rd_idx + 1'b1;
      end

      if (pel_adr_rd)
        dac_state <= 2'b11;
      else if (pel_adr_wr)
        dac_state <= 2'b00;
    end
  end

  always_comb
  begin
    case (dac_rd_cyc)
      2'd0:    dac_comp = dac_rdata_i.red;
      2'd1:    dac_comp = dac_rdata_i.green;
      default: dac_comp = dac_rdata_i.blue;
    endcase
  end

  assign graph_rd = (graph_idx < `VGA_GRAPH_REGS) ? graph_file[graph_idx] : 8'h00;
  assign crtc_rd  = (crtc_idx < `VGA_CRTC_REGS) ? crtc_file[crtc_idx] : 8'h00;

  always_comb
  begin
    case (wb_req_i.adr)
      `VGA_ADR_ATTR:   wb_dat_o = {attr_rdata_i, 3'b001, pal_hi, pal_addr};
      `VGA_ADR_SEQ:    wb_dat_o = {8'h00, seq_idx, map_mask_o};
      `VGA_ADR_PEL_RD: wb_dat_o = {6'h00, dac_state, 8'hff};
      `VGA_ADR_DAC:    wb_dat_o = {2'b00, dac_comp, dac_wr_idx};
      `VGA_ADR_GRAPH:  wb_dat_o = {4'h0, graph_idx, graph_rd};
      `VGA_ADR_CRTC:   wb_dat_o = {3'h0, crtc_idx, crtc_rd};
      `VGA_ADR_STATUS: wb_dat_o = {12'h000, v_retrace_i, 2'b00, vh_retrace_i};
      default:         wb_dat_o = '0;
    endcase
  end

  // field decode
  always_comb
  begin
    graph_cfg_o.set_reset     = graph_file[0][3:0];
    graph_cfg_o.en_set_reset  = graph_file[1][3:0];
    graph_cfg_o.color_compare = graph_file[2][3:0];
    graph_cfg_o.raster_op     = graph_file[3][4:3];
    graph_cfg_o.read_map_sel  = graph_file[4][1:0];
    graph_cfg_o.write_mode    = graph_file[5][1:0];
    graph_cfg_o.read_mode     = graph_file[5][3];
    graph_cfg_o.shift_mode    = graph_file[5][6];
    graph_cfg_o.alpha_mode    = graph_file[6][0];
    graph_cfg_o.mem_mapping   = graph_file[6][3];
    graph_cfg_o.dont_care     = graph_file[7][3:0];
    graph_cfg_o.bit_mask      = graph_file[8];
  end

  always_comb
  begin
    crtc_cfg_o.cur_start    = crtc_file[10][5:0];
    crtc_cfg_o.cur_end      = crtc_file[11][5:0];
    crtc_cfg_o.start_addr   = {crtc_file[12], crtc_file[13]};
    crtc_cfg_o.vcursor      = crtc_file[14][4:0];
    crtc_cfg_o.hcursor      = crtc_file[15][6:0];
    crtc_cfg_o.horiz_total  = crtc_file[0][6:0];
    crtc_cfg_o.end_horiz    = crtc_file[1][6:0];
    crtc_cfg_o.st_hor_retr  = crtc_file[4][6:0];
    crtc_cfg_o.end_hor_retr = crtc_file[5][4:0];
    // overflow register 7 supplies bits 9:8
    crtc_cfg_o.vert_total   = {crtc_file[7][5], crtc_file[7][0], crtc_file[6]};
    crtc_cfg_o.end_vert     = {crtc_file[7][6], crtc_file[7][1], crtc_file[18]};
    crtc_cfg_o.st_ver_retr  = {crtc_file[7][7], crtc_file[7][2], crtc_file[16]};
    crtc_cfg_o.end_ver_retr = crtc_file[17][3:0];
  end

endmodule

//--- hdl/vga_palette_top.sv
// top level of the register and colour path: wishbone register block,
// attribute palette and dac tables, and the two-stage pixel lookup
`timescale 1ns/1ps
`include "vga_params.svh"

module vga_palette_top
  import vga_bus_pkg::*;
  import vga_regs_pkg::*;
(
  input  logic                    wb_clk_i,
  input  logic                    arst_n_i,
  input  logic [`VGA_DAT_W-1:0]   wb_dat_i,
  output logic [`VGA_DAT_W-1:0]   wb_dat_o,
  input  logic [`VGA_ADR_W-1:0]   wb_adr_i,
  input  logic                    wb_we_i,
  input  logic [1:0]              wb_sel_i,
  input  logic                    wb_stb_i,
  output logic                    wb_ack_o,
  output graph_cfg_t              graph_cfg_o,
  output crtc_cfg_t               crtc_cfg_o,
  output logic [3:0]              map_mask_o,
  input  logic                    v_retrace_i,
  input  logic                    vh_retrace_i,
  input  logic [`VGA_ATTR_AW-1:0] pixel_i,
  output rgb18_t                  rgb_o
);

  wb_req_t                 wb_req;
  logic                    attr_we;
  logic [`VGA_ATTR_AW-1:0] attr_addr;
  attr_entry_t             attr_wdata, attr_rdata;
  attr_entry_t             attr_vid;  // dac index of the pixel in flight
  logic                    dac_we;
  logic [`VGA_DAC_AW-1:0]  dac_addr;
  rgb18_t                  dac_wdata, dac_rdata;

  assign wb_req = '{dat: wb_dat_i, adr: wb_adr_i, we: wb_we_i, sel: wb_sel_i, stb: wb_stb_i};

  vga_config_regs vga_config_regs_inst (
    .wb_clk_i     (wb_clk_i),
    .arst_n_i     (arst_n_i),
    .wb_req_i     (wb_req),
    .wb_dat_o     (wb_dat_o),
    .wb_ack_o     (wb_ack_o),
    .graph_cfg_o  (graph_cfg_o),
    .crtc_cfg_o   (crtc_cfg_o),
    .map_mask_o   (map_mask_o),
    .attr_we_o    (attr_we),
    .attr_addr_o  (attr_addr),
    .attr_wdata_o (attr_wdata),
    .attr_rdata_i (attr_rdata),
    .dac_we_o     (dac_we),
    .dac_addr_o   (dac_addr),
    .dac_wdata_o  (dac_wdata),
    .dac_rdata_i  (dac_rdata),
    .v_retrace_i  (v_retrace_i),
    .vh_retrace_i (vh_retrace_i)
  );

  // stage 1, pixel to dac index
  lut_ram #(.entry_t(attr_entry_t), .DEPTH(`VGA_ATTR_DEPTH)) attr_table (
    .wb_clk_i     (wb_clk_i),
    .host_we_i    (attr_we),
    .host_addr_i  (attr_addr),
    .host_wdata_i (attr_wdata),
    .host_rdata_o (attr_rdata),
    .vid_addr_i   (pixel_i),
    .vid_rdata_o  (attr_vid)
  );

  // stage 2, dac index to rgb
  lut_ram #(.entry_t(rgb18_t), .DEPTH(`VGA_DAC_DEPTH)) dac_table (
    .wb_clk_i     (wb_clk_i),
    .host_we_i    (dac_we),
    .host_addr_i  (dac_addr),
    .host_wdata_i (dac_wdata),
    .host_rdata_o (dac_rdata),
    .vid_addr_i   (attr_vid),
    .vid_rdata_o  (rgb_o)
  );

endmodule

//--- hdl/vga_params.svh
// address map, table depths and field widths of the VGA register and palette block
// include wherever bus addresses or widths are needed
`ifndef VGA_PARAMS_SVH
`define VGA_PARAMS_SVH

// host bus
`define VGA_DAT_W 16
`define VGA_ADR_W 4

// word addresses on the 4-bit host address
`define VGA_ADR_ATTR   4'd0   // attribute controller, flip-flop driven
`define VGA_ADR_SEQ    4'd2
`define VGA_ADR_PEL_RD 4'd3   // dac read index, dac state on read
`define VGA_ADR_DAC    4'd4   // dac write index (low) and data (high)
`define VGA_ADR_GRAPH  4'd7
`define VGA_ADR_CRTC   4'd10
`define VGA_ADR_STATUS 4'd13  // input status 1

// colour tables
`define VGA_ATTR_DEPTH 16
`define VGA_DAC_DEPTH  256
`define VGA_ATTR_AW    4
`define VGA_DAC_AW     8
`define VGA_COMP_W     6

// register files and their indices
`define VGA_CRTC_REGS    24
`define VGA_GRAPH_REGS   9
`define VGA_SEQ_IDX_W    4
`define VGA_GRAPH_IDX_W  4
`define VGA_CRTC_IDX_W   5
`define VGA_SEQ_MAP_MASK 4'd2

`endif

//--- hdl/vga_regs_pkg.sv
// decoded graphics controller and crtc fields
// handed to the memory and timing units by the register block
package vga_regs_pkg;

  typedef struct packed {
    logic [3:0] set_reset;     // gr0
    logic [3:0] en_set_reset;  // gr1
    logic [3:0] color_compare; // gr2
    logic [1:0] raster_op;     // gr3
    logic [1:0] read_map_sel;  // gr4
    logic [1:0] write_mode;    // gr5
    logic       read_mode;
    logic       shift_mode;
    logic       alpha_mode;    // gr6
    logic       mem_mapping;
    logic [3:0] dont_care;     // gr7
    logic [7:0] bit_mask;      // gr8
  } graph_cfg_t;

  typedef struct packed {
    // cursor
    logic [5:0]  cur_start;
    logic [5:0]  cur_end;
    logic [15:0] start_addr;
    logic [4:0]  vcursor;
    logic [6:0]  hcursor;

    // horizontal timing in character clocks
    logic [6:0]  horiz_total;
    logic [6:0]  end_horiz;
    logic [6:0]  st_hor_retr;
    logic [4:0]  end_hor_retr;

    // vertical timing, two top bits from the overflow register
    logic [9:0]  vert_total;
    logic [9:0]  end_vert;
    logic [9:0]  st_ver_retr;
    logic [3:0]  end_ver_retr;
  } crtc_cfg_t;

endpackage

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and looks for the pass line in the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=tb_vga_palette

if ! verilator --binary --timing --assert -Wno-fatal -f files.f \
    --top-module tb_vga_palette --Mdir "$OBJ" -o "$BIN"; then
  echo "verilator compile failed"
  exit 1
fi

if ! "./$OBJ/$BIN" > "$LOG" 2>&1; then
  cat "$LOG"
  echo "simulation exited with an error status"
  exit 1
fi
cat "$LOG"

if grep -qx '>>> PASS' "$LOG"; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed, see $LOG"
exit 1

//--- tests/tb_vga_palette.sv
// random host traffic on the vga register and palette block checked against
// a reference model, followed by a streamed pixel lookup check
`timescale 1ns/1ps
`include "vga_params.svh"

module tb_vga_palette
  import vga_bus_pkg::*;
  import vga_regs_pkg::*;
();

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 8;
  localparam int N_GRAPH      = 40;
  localparam int N_CRTC       = 80;
  localparam int N_SEQ        = 24;
  localparam int N_ATTR       = 32;
  localparam int N_ROUNDS     = 2;
  localparam int N_TRIPLES    = 32;
  localparam int N_STATUS     = 16;
  localparam int N_PIX        = 200;
  localparam int ACK_LIMIT    = 16;
  // bus operations over all tests take well under 4 cycles each
  localparam int BUS_OPS    = 2 * (N_GRAPH + N_CRTC + N_SEQ) + 5 * N_ATTR
                            + N_ROUNDS * (4 + 6 * N_TRIPLES) + N_STATUS + 1;
  localparam int RUN_CYCLES = BUS_OPS * 4 + N_PIX + 2 + RESET_CYCLES + 100;

  logic                  wb_clk_i = 1'b0;
  logic                  arst_n_i;
  logic [`VGA_DAT_W-1:0] wb_dat_i, wb_dat_o;
  logic [`VGA_ADR_W-1:0] wb_adr_i;
  logic                  wb_we_i, wb_stb_i, wb_ack_o;
  logic [1:0]            wb_sel_i;
  graph_cfg_t            graph_cfg_o;
  crtc_cfg_t             crtc_cfg_o;
  logic [3:0]            map_mask_o;
  logic                  v_retrace_i, vh_retrace_i;
  logic [3:0]            pixel_i;
  rgb18_t                rgb_o;

  integer seed;
  int     n_errors, n_checks;

  // reference model state
  logic [7:0]  graph_m [`VGA_GRAPH_REGS];
  logic [7:0]  crtc_m [`VGA_CRTC_REGS];
  logic [3:0]  seq_idx_m, graph_idx_m, map_mask_m;
  logic [4:0]  crtc_idx_m;
  logic        ff_m;
  logic [4:0]  pal_adr_m;  // bit 4 blocks palette writes
  attr_entry_t attr_m [`VGA_ATTR_DEPTH];
  rgb18_t      dac_m [`VGA_DAC_DEPTH];
  logic [7:0]  wr_idx_m, rd_idx_m;
  logic [1:0]  wr_cyc_m, rd_cyc_m, dac_state_m;
  logic [5:0]  red_m, green_m;

  vga_palette_top vga_palette_top_inst (
    .wb_clk_i     (wb_clk_i),
    .arst_n_i     (arst_n_i),
    .wb_dat_i     (wb_dat_i),
    .wb_dat_o     (wb_dat_o),
    .wb_adr_i     (wb_adr_i),
    .wb_we_i      (wb_we_i),
    .wb_sel_i     (wb_sel_i),
    .wb_stb_i     (wb_stb_i),
    .wb_ack_o     (wb_ack_o),
    .graph_cfg_o  (graph_cfg_o),
    .crtc_cfg_o   (crtc_cfg_o),
    .map_mask_o   (map_mask_o),
    .v_retrace_i  (v_retrace_i),
    .vh_retrace_i (vh_retrace_i),
    .pixel_i      (pixel_i),
    .rgb_o        (rgb_o)
  );

  bind vga_config_regs vga_palette_assertions assertions_inst (
    .wb_clk_i    (wb_clk_i),
    .arst_n_i    (arst_n_i),
    .wb_req_i    (wb_req_i),
    .wb_ack_i    (wb_ack_o),
    .flip_flop_i (flip_flop)
  );

  always #(CLK_PERIOD / 2) wb_clk_i = ~wb_clk_i;

  initial
  begin
    #(RUN_CYCLES * CLK_PERIOD);
    $display("timeout: run not finished after %0d cycles, %0d errors so far",
             RUN_CYCLES, n_errors);
    $display(">>> FAIL");
    $finish;
  end

  function automatic logic [31:0] next_rand();
    next_rand = $random(seed);
  endfunction

  // standard vga bit positions of the graphics registers
  function automatic graph_cfg_t graph_expect();
    graph_expect = {graph_m[0][3:0], graph_m[1][3:0], graph_m[2][3:0], graph_m[3][4:3],
                    graph_m[4][1:0], graph_m[5][1:0], graph_m[5][3], graph_m[5][6],
                    graph_m[6][0], graph_m[6][3], graph_m[7][3:0], graph_m[8]};
  endfunction

  // vertical values take bits 9:8 from overflow register 7
  function automatic crtc_cfg_t crtc_expect();
    crtc_expect = {crtc_m[10][5:0], crtc_m[11][5:0], crtc_m[12], crtc_m[13],
                   crtc_m[14][4:0], crtc_m[15][6:0], crtc_m[0][6:0], crtc_m[1][6:0],
                   crtc_m[4][6:0], crtc_m[5][4:0],
                   crtc_m[7][5], crtc_m[7][0], crtc_m[6],
                   crtc_m[7][6], crtc_m[7][1], crtc_m[18],
                   crtc_m[7][7], crtc_m[7][2], crtc_m[16], crtc_m[17][3:0]};
  endfunction

  function automatic logic [5:0] dac_comp_expect(input rgb18_t e, input logic [1:0] cyc);
    case (cyc)
      2'd0:    dac_comp_expect = e.red;
      2'd1:    dac_comp_expect = e.green;
      default: dac_comp_expect = e.blue;
    endcase
  endfunction

  task automatic check_val(input logic [127:0] actual, input logic [127:0] expected,
                           input string what);
    n_checks++;
    if (actual !== expected)
    begin
      n_errors++;
      $display("FAILED at %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
    end
  endtask

  // one wishbone cycle with strobe held until ack and an idle cycle after
  task automatic wb_cycle(input logic [3:0] adr, input logic we, input logic [1:0] sel,
                          input logic [15:0] dat, output logic [15:0] rdata);
    int waited;
    waited = 0;
    @(posedge wb_clk_i);
    wb_adr_i <= adr;
    wb_we_i  <= we;
    wb_sel_i <= sel;
    wb_dat_i <= dat;
    wb_stb_i <= 1'b1;
    @(negedge wb_clk_i);
    while (!wb_ack_o && waited < ACK_LIMIT)
    begin
      @(negedge wb_clk_i);
      waited++;
    end
    if (!wb_ack_o)
    begin
      n_errors++;
      $display("no acknowledge from the DUT at %0t ns for address %0d", $time, adr);
    end
    rdata = wb_dat_o;
    @(posedge wb_clk_i);
    wb_stb_i <= 1'b0;
    wb_we_i  <= 1'b0;
  endtask

  task automatic write_reg(input logic [3:0] adr, input logic [1:0] sel,
                           input logic [15:0] dat);
    logic [15:0] unused;
    wb_cycle(adr, 1'b1, sel, dat, unused);
  endtask

  task automatic read_reg(input logic [3:0] adr, input logic [1:0] sel,
                          output logic [15:0] rdata);
    wb_cycle(adr, 1'b0, sel, 16'h0000, rdata);
  endtask

  task automatic attr_write(input logic [7:0] d);
    write_reg(`VGA_ADR_ATTR, 2'b01, {8'h00, d});
    if (!ff_m)
      pal_adr_m = d[4:0];
    else if (!pal_adr_m[4])
      attr_m[pal_adr_m[3:0]] = d;
    ff_m = ~ff_m;
  endtask

  task automatic status_read(output logic [15:0] rd);
    read_reg(`VGA_ADR_STATUS, 2'b01, rd);
    ff_m = 1'b0;
  endtask

  task automatic program_graph_crtc();
    logic [31:0] r;
    logic [15:0] rd;
    logic [7:0]  d;
    logic [1:0]  sel;
    for (int i = 0; i < N_GRAPH; i++)
    begin
      r = next_rand();
      sel = (r[13:12] == 2'b00) ? 2'b01 : 2'b11;  // some index-only writes
      write_reg(`VGA_ADR_GRAPH, sel, {r[11:4], 4'h0, r[3:0]});
      graph_idx_m = r[3:0];
      if (sel[1] && graph_idx_m < `VGA_GRAPH_REGS)
        graph_m[graph_idx_m] = r[11:4];
      d = (graph_idx_m < `VGA_GRAPH_REGS) ? graph_m[graph_idx_m] : 8'h00;
      read_reg(`VGA_ADR_GRAPH, 2'b11, rd);
      check_val(rd, {4'h0, graph_idx_m, d}, "graphics read-back");
      @(negedge wb_clk_i);
      check_val(graph_cfg_o, graph_expect(), "graph_cfg_o decode");
    end
    for (int i = 0; i < N_CRTC; i++)
    begin
      r = next_rand();
      sel = (r[14:13] == 2'b00) ? 2'b01 : 2'b11;
      write_reg(`VGA_ADR_CRTC, sel, {r[12:5], 3'h0, r[4:0]});
      crtc_idx_m = r[4:0];
      if (sel[1] && crtc_idx_m < `VGA_CRTC_REGS)
        crtc_m[crtc_idx_m] = r[12:5];
      d = (crtc_idx_m < `VGA_CRTC_REGS) ? crtc_m[crtc_idx_m] : 8'h00;
      read_reg(`VGA_ADR_CRTC, 2'b11, rd);
      check_val(rd, {3'h0, crtc_idx_m, d}, "crtc read-back");
      @(negedge wb_clk_i);
      check_val(crtc_cfg_o, crtc_expect(), "crtc_cfg_o decode");
    end
  endtask

  task automatic program_map_mask();
    logic [31:0] r;
    logic [15:0] rd, dat;
    logic [1:0]  sel;
    for (int i = 0; i < N_SEQ; i++)
    begin
      r = next_rand();
      sel = (r[6:5] == 2'b00) ? 2'b11 : r[6:5];
      dat = {r[15:8], 4'h0, (r[4] ? 4'd2 : r[3:0])};  // map mask index half the time
      write_reg(`VGA_ADR_SEQ, sel, dat);
      if (sel[0])
        seq_idx_m = dat[3:0];
      if (sel[1] && seq_idx_m == 4'd2)
        map_mask_m = dat[11:8];
      read_reg(`VGA_ADR_SEQ, 2'b11, rd);
      check_val(rd, {8'h00, seq_idx_m, map_mask_m}, "sequencer read-back");
      @(negedge wb_clk_i);
      check_val(map_mask_o, map_mask_m, "map_mask_o");
    end
  endtask

  task automatic load_attr_palette();
    logic [31:0] r;
    logic [15:0] rd;
    for (int i = 0; i < N_ATTR; i++)
    begin
      r = next_rand();
      if (r[20])
        attr_write({3'b000, r[25:21]});  // leaves the flip-flop set for the status read
      status_read(rd);
      attr_write({3'b000, r[6] & r[5], r[3:0]});
      attr_write(r[15:8]);
      read_reg(`VGA_ADR_ATTR, 2'b10, rd);
      check_val(rd, {attr_m[pal_adr_m[3:0]], 3'b001, pal_adr_m}, "attribute read-back");
    end
  endtask

  task automatic load_dac();
    logic [31:0] r;
    logic [15:0] rd;
    logic [7:0]  start;
    for (int k = 0; k < N_ROUNDS; k++)
    begin
      r = next_rand();
      start = r[7:0];
      write_reg(`VGA_ADR_DAC, 2'b01, {8'h00, start});
      wr_idx_m = start;
      wr_cyc_m = 2'd0;
      dac_state_m = 2'b00;
      read_reg(`VGA_ADR_PEL_RD, 2'b11, rd);
      check_val(rd, {6'h00, dac_state_m, 8'hff}, "dac state after write index");
      for (int t = 0; t < 3 * N_TRIPLES; t++)
      begin
        r = next_rand();
        write_reg(`VGA_ADR_DAC, 2'b10, {2'b00, r[5:0], 8'h00});
        case (wr_cyc_m)
          2'd0: red_m = r[5:0];
          2'd1: green_m = r[5:0];
          default:
          begin
            dac_m[wr_idx_m] = {red_m, green_m, r[5:0]};
            wr_idx_m++;
          end
        endcase
        wr_cyc_m = (wr_cyc_m == 2'd2) ? 2'd0 : wr_cyc_m + 2'd1;
      end
      write_reg(`VGA_ADR_PEL_RD, 2'b10, {start, 8'h00});
      rd_idx_m = start;
      rd_cyc_m = 2'd0;
      dac_state_m = 2'b11;
      read_reg(`VGA_ADR_PEL_RD, 2'b11, rd);
      check_val(rd, {6'h00, dac_state_m, 8'hff}, "dac state after read index");
      for (int t = 0; t < 3 * N_TRIPLES; t++)
      begin
        read_reg(`VGA_ADR_DAC, 2'b10, rd);
        check_val(rd, {2'b00, dac_comp_expect(dac_m[rd_idx_m], rd_cyc_m), wr_idx_m},
                  "dac read-back");
        if (rd_cyc_m == 2'd2)
          rd_idx_m++;
        rd_cyc_m = (rd_cyc_m == 2'd2) ? 2'd0 : rd_cyc_m + 2'd1;
      end
    end
  endtask

  // pixel driven at edge i comes out as rgb after edge i+2
  task automatic stream_pixels();
    logic [31:0] r;
    logic [3:0]  pix [N_PIX + 2];
    for (int i = 0; i < N_PIX + 2; i++)
    begin
      r = next_rand();
      @(posedge wb_clk_i);
      pixel_i <= r[3:0];
      pix[i] = r[3:0];
      @(negedge wb_clk_i);
      if (i >= 2)
        check_val(rgb_o, dac_m[attr_m[pix[i-2]]], "rgb_o for streamed pixel");
    end
  endtask

  task automatic sample_retrace();
    logic [31:0] r;
    logic [15:0] rd;
    for (int i = 0; i < N_STATUS; i++)
    begin
      r = next_rand();
      @(posedge wb_clk_i);
      v_retrace_i  <= r[0];
      vh_retrace_i <= r[1];
      status_read(rd);
      check_val(rd, {12'h000, r[0], 2'b00, r[1]}, "status word");
    end
  endtask

  initial
  begin
    logic [15:0] rd;
    seed = 90869;
    n_errors = 0;
    n_checks = 0;
    arst_n_i = 1'b0;
    wb_dat_i = '0;
    wb_adr_i = '0;
    wb_we_i = 1'b0;
    wb_sel_i = 2'b00;
    wb_stb_i = 1'b0;
    v_retrace_i = 1'b0;
    vh_retrace_i = 1'b0;
    pixel_i = '0;
    for (int i = 0; i < `VGA_GRAPH_REGS; i++)
      graph_m[i] = 8'h00;
    for (int i = 0; i < `VGA_CRTC_REGS; i++)
      crtc_m[i] = 8'h00;
    for (int i = 0; i < `VGA_ATTR_DEPTH; i++)
      attr_m[i] = '0;
    for (int i = 0; i < `VGA_DAC_DEPTH; i++)
      dac_m[i] = '0;
    {seq_idx_m, graph_idx_m, crtc_idx_m, map_mask_m, ff_m, pal_adr_m} = '0;
    {wr_idx_m, rd_idx_m, wr_cyc_m, rd_cyc_m} = '0;
    dac_state_m = 2'b01;
    repeat (RESET_CYCLES) @(posedge wb_clk_i);
    arst_n_i <= 1'b1;
    @(negedge wb_clk_i);
    check_val(wb_ack_o, 1'b0, "ack idle after reset");
    read_reg(`VGA_ADR_PEL_RD, 2'b11, rd);
    check_val(rd, {6'h00, dac_state_m, 8'hff}, "dac state after reset");
    program_graph_crtc();
    program_map_mask();
    load_attr_palette();
    load_dac();
    stream_pixels();
    sample_retrace();
    @(posedge wb_clk_i);
    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

//--- tests/vga_palette_assertions.sv
// concurrent checks on the register block's acknowledge and attribute flip-flop
// bound into vga_config_regs by the testbench
`timescale 1ns/1ps
`include "vga_params.svh"

module vga_palette_assertions
  import vga_bus_pkg::*;
(
  input logic    wb_clk_i,
  input logic    arst_n_i,
  input wb_req_t wb_req_i,
  input logic    wb_ack_i,
  input logic    flip_flop_i
);

  logic tbl_rd, attr_wr, status_rd;

  assign tbl_rd    = wb_req_i.stb && !wb_req_i.we && wb_req_i.sel[1] &&
                     (wb_req_i.adr == `VGA_ADR_ATTR || wb_req_i.adr == `VGA_ADR_DAC);
  assign attr_wr   = wb_req_i.stb && wb_req_i.we && wb_req_i.sel[0] &&
                     wb_req_i.adr == `VGA_ADR_ATTR;
  assign status_rd = wb_req_i.stb && !wb_req_i.we && wb_req_i.sel[0] &&
                     wb_req_i.adr == `VGA_ADR_STATUS;

  write_ack: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
    wb_req_i.stb && wb_req_i.we |-> wb_ack_i)
    else $error("write not acknowledged in its strobe cycle");

  // table data is registered, so no ack in the first cycle
  tbl_ack_wait: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
    $rose(tbl_rd) |-> !wb_ack_i)
    else $error("table read acknowledged before its data was ready");

  tbl_ack_late: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
    $rose(tbl_rd) |=> wb_ack_i)
    else $error("table read not acknowledged one cycle after the strobe");

  ff_toggle: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
    attr_wr |=> flip_flop_i != $past(flip_flop_i))
    else $error("attribute flip-flop did not toggle on an attribute write");

  ff_clear: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
    status_rd |=> !flip_flop_i)
    else $error("attribute flip-flop not cleared by a status read");

endmodule
